// ==== bench/memUnitBind_assert.sv ====
`timescale 1ns/1ps

module memUnitChecks (
   input logic            clk,
   input logic            rstN,
   input apbPkg::apbReq_t apbReq,
   input logic            validA,
   input logic            validB,
   input logic            enB
);

   // access phase only after a selected setup
   penableAfterPsel: assert property (@(posedge clk) disable iff (!rstN)
      apbReq.penable |-> (apbReq.psel && $past(apbReq.psel)))
      else $error("penable seen without psel");

   validsLowInReset: assert property (@(posedge clk)
      !rstN |=> (!validA && !validB))
      else $error("stream valid high during reset");

   // ram latency plus output register
   validBFollowsEnB: assert property (@(posedge clk) disable iff (!rstN)
      validB == $past(enB, 2))
      else $error("validB does not follow enB by two cycles");

endmodule

bind memUnitTop memUnitChecks checks (
   .clk   (clk),
   .rstN  (rstN),
   .apbReq(apbReq),
   .validA(validA),
   .validB(validB),
   .enB   (enB)
);

// ==== bench/memUnitTb.sv ====
`timescale 1ns/1ps

module memUnitTb;
   import apbPkg::*;
   import memUnitPkg::*;

   localparam int DATA_W = 16;
   localparam int ADDR_W = 6;
   localparam int DEPTH = 1 << ADDR_W;
   localparam logic [31:0] SEED = 32'd33;
   // six tests need about 1400 cycles, twice that rounded up
   localparam int TIMEOUT_CYCLES = 3000;

   logic              clk = 1'b0;
   logic              rstN;
   apbReq_t           apbReq;
   apbRsp_t           apbRsp;
   logic [DATA_W-1:0] dataIn = '0;
   logic [DATA_W-1:0] dataA;
   logic              validA;
   logic [DATA_W-1:0] dataB;
   logic              validB;

   logic [31:0]       stimState;
   logic [31:0]       dinState = ~SEED;
   int                cycleCnt = 0;
   int                accessCycle;
   int                errCnt;
   int                checkCnt;
   int                testErrStart;
   logic [DATA_W-1:0] model [DEPTH];
   logic [DATA_W-1:0] dinHist [4096];
   logic [ADDR_W-1:0] expAddr [$];
   logic [ADDR_W-1:0] expAddrA [$];
   int                expOffs [$];
   logic [DATA_W-1:0] streamA [$];
   logic [DATA_W-1:0] streamB [$];

   memUnitTop #(
      .dataW(DATA_W),
      .addrW(ADDR_W)
   ) uut (
      .clk   (clk),
      .rstN  (rstN),
      .apbReq(apbReq),
      .apbRsp(apbRsp),
      .dataIn(dataIn),
      .dataA (dataA),
      .validA(validA),
      .dataB (dataB),
      .validB(validB)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a wait for the DUT never ended", cycleCnt);
         $display("Test failures found");
         $finish;
      end
   end

   // free running source, every word kept by cycle
   always @(negedge clk) begin
      dinState = lcgNext(dinState);
      dataIn = dinState[23:8];
      dinHist[cycleCnt % 4096] = dataIn;
   end

   always @(negedge clk) begin
      if (validA) begin
         streamA.push_back(dataA);
      end
      if (validB) begin
         streamB.push_back(dataB);
      end
   end

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function logic [31:0] randWord();
      stimState = lcgNext(stimState);
      return stimState ^ (stimState >> 15);
   endfunction

   function int randRange(input int lo, input int hi);
      stimState = lcgNext(stimState);
      return lo + int'(stimState[30:8]) % (hi - lo + 1);
   endfunction

   function automatic logic [ADDR_W-1:0] reverseBits(input logic [ADDR_W-1:0] a);
      logic [ADDR_W-1:0] r;
      for (int i = 0; i < ADDR_W; i++) begin
         r[i] = a[ADDR_W-1-i];
      end
      return r;
   endfunction

   function automatic logic [11:0] memAddr(input int idx);
      return 12'h800 | 12'(idx * 4);
   endfunction

   // bits kept by each of the three config words
   function automatic logic [31:0] cfgMask(input int word);
      case (word)
         0: return 32'h3fff_ffff;
         1: return 32'h003f_ffff;
         default: return 32'h0000_00ff;
      endcase
   endfunction

   function automatic agCfg_t randomCfg(input logic rev, input logic we);
      agCfg_t c;
      c = '0;
      c.start = 10'(randRange(0, DEPTH - 1));
      c.incr = 10'(randRange(0, DEPTH - 1));
      c.shift = 10'(randRange(0, DEPTH - 1));
      c.iterations = 10'(randRange(1, 6));
      c.period = 6'(randRange(1, 8));
      c.duty = 6'(randRange(1, 9));
      c.delay = 6'(randRange(0, 15));
      c.reverse = rev;
      c.writeEn = we;
      return c;
   endfunction

   task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] got);
      checkCnt++;
      if (got !== exp) begin
         errCnt++;
         $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
      end
   endtask

   task automatic report(input int num, input string name);
      if (errCnt == testErrStart) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errCnt - testErrStart);
      end
      testErrStart = errCnt;
   endtask

   // setup, access, then one idle cycle
   task automatic transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(negedge clk);
      apbReq.psel = 1'b1;
      apbReq.penable = 1'b0;
      apbReq.pwrite = wr;
      apbReq.paddr = addr;
      apbReq.pwdata = wdata;
      @(negedge clk);
      apbReq.penable = 1'b1;
      accessCycle = cycleCnt;
      #1;
      rdata = apbRsp.prdata;
      err = apbRsp.pslverr;
      @(negedge clk);
      apbReq.psel = 1'b0;
      apbReq.penable = 1'b0;
      apbReq.pwrite = 1'b0;
   endtask

   task automatic writeReg(input logic [11:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic err;
      transfer(1'b1, addr, data, rd, err);
      expectEq("pslverr", 32'h0, 32'(err));
   endtask

   task automatic readReg(input logic [11:0] addr, output logic [31:0] data);
      logic err;
      transfer(1'b0, addr, 32'h0, data, err);
      expectEq("pslverr", 32'h0, 32'(err));
   endtask

   task automatic setCfg(input logic portB, input agCfg_t c);
      logic [11:0] base;
      base = portB ? 12'h014 : 12'h008;
      writeReg(base, {2'b0, c.shift, c.incr, c.start});
      writeReg(base + 12'h4, {10'b0, c.duty, c.period, c.iterations});
      writeReg(base + 12'h8, {24'b0, c.writeEn, c.reverse, c.delay});
   endtask

   // expected addresses and their run cycle, in generator order
   task automatic buildAddrList(input agCfg_t c);
      logic [ADDR_W-1:0] a;
      int per;
      int its;
      a = c.start[ADDR_W-1:0];
      per = (c.period == 0) ? 1 : int'(c.period);
      its = (c.iterations == 0) ? 1 : int'(c.iterations);
      expAddr.delete();
      expOffs.delete();
      for (int p = 0; p < its; p++) begin
         for (int i = 0; i < per; i++) begin
            if (i < int'(c.duty)) begin
               expAddr.push_back(c.reverse ? reverseBits(a) : a);
               expOffs.push_back(p * per + i);
               a = a + c.incr[ADDR_W-1:0];
            end
         end
         a = a + c.shift[ADDR_W-1:0];
      end
   endtask

   task automatic startRun();
      writeReg(12'h000, 32'h1);
   endtask

   task automatic waitIdle();
      logic [31:0] st;
      st = 32'h1;
      while (st[0]) begin
         readReg(12'h004, st);
      end
      expectEq("status", 32'h6, st);
      // last reads still in the output pipeline
      repeat (3) @(negedge clk);
   endtask

   task automatic checkMemory();
      logic [31:0] rd;
      for (int i = 0; i < DEPTH; i++) begin
         readReg(memAddr(i), rd);
         expectEq("prdata", 32'(model[i]), rd);
      end
   endtask

   task automatic checkStream(input string name, input logic [ADDR_W-1:0] addrs [$],
                              input logic [DATA_W-1:0] words [$]);
      expectEq({name, " count"}, 32'(addrs.size()), 32'(words.size()));
      foreach (addrs[k]) begin
         if (k < words.size()) begin
            expectEq(name, 32'(model[addrs[k]]), 32'(words[k]));
         end
      end
   endtask

   // both ports read side by side
   task automatic runReadPorts(input logic rev);
      agCfg_t cA;
      agCfg_t cB;
      cA = randomCfg(1'b0, 1'b0);
      cB = randomCfg(rev, 1'b0);
      setCfg(1'b0, cA);
      setCfg(1'b1, cB);
      buildAddrList(cA);
      expAddrA = expAddr;
      buildAddrList(cB);
      streamA.delete();
      streamB.delete();
      startRun();
      waitIdle();
      checkStream("dataA", expAddrA, streamA);
      checkStream("dataB", expAddr, streamB);
   endtask

   initial begin
      agCfg_t      c;
      int          runCycle;
      logic [31:0] rd;
      logic        err;
      logic [31:0] vals [6];
      rstN = 1'b0;
      apbReq = '0;
      stimState = SEED;
      errCnt = 0;
      checkCnt = 0;
      testErrStart = 0;
      repeat (5) @(negedge clk);
      rstN = 1'b1;

      for (int r = 0; r < 6; r++) begin
         vals[r] = randWord();
         writeReg(12'h008 + 12'(4 * r), vals[r]);
      end
      for (int r = 0; r < 6; r++) begin
         readReg(12'h008 + 12'(4 * r), rd);
         expectEq("prdata", vals[r] & cfgMask(r % 3), rd);
      end
      transfer(1'b1, 12'h004, 32'h1, rd, err);
      expectEq("pslverr", 32'h1, 32'(err));
      report(1, "config registers");

      for (int i = 0; i < DEPTH; i++) begin
         rd = randWord();
         model[i] = rd[DATA_W-1:0];
         writeReg(memAddr(i), 32'(model[i]));
      end
      checkMemory();
      report(2, "host memory window");

      runReadPorts(1'b0);
      report(3, "port B read run");

      c = randomCfg(1'b0, 1'b1);
      setCfg(1'b1, '0);
      setCfg(1'b0, c);
      buildAddrList(c);
      streamA.delete();
      startRun();
      runCycle = accessCycle;
      waitIdle();
      // port A writes raise no valid
      expectEq("validA count", 32'h0, 32'(streamA.size()));
      // run cycles start two cycles plus delay after the ctrl access
      foreach (expAddr[k]) begin
         model[expAddr[k]] = dinHist[(runCycle + 2 + int'(c.delay) + expOffs[k]) % 4096];
      end
      checkMemory();
      report(4, "port A write run");

      runReadPorts(1'b1);
      report(5, "port B bit reversed run");

      c = randomCfg(1'b0, 1'b0);
      c.delay = 6'd40;
      c.period = 6'd8;
      c.iterations = 10'd6;
      setCfg(1'b0, '0);
      setCfg(1'b1, c);
      buildAddrList(c);
      streamB.delete();
      startRun();
      readReg(12'h004, rd);
      expectEq("status busy", 32'h1, 32'(rd[0]));
      transfer(1'b1, memAddr(9), 32'(~model[9]), rd, err);
      expectEq("pslverr", 32'h1, 32'(err));
      transfer(1'b0, memAddr(9), 32'h0, rd, err);
      expectEq("pslverr", 32'h1, 32'(err));
      waitIdle();
      checkStream("dataB", expAddr, streamB);
      checkMemory();
      runReadPorts(1'b0);
      report(6, "busy and restart");

      $display("%0d checks, %0d errors", checkCnt, errCnt);
      if (errCnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/memUnitPkg.sv
rtl/apbPkg.sv
rtl/addrGen.sv
rtl/dualPortRam.sv
rtl/portCombiner.sv
rtl/apbCfgRegs.sv
rtl/memUnitTop.sv
bench/memUnitBind_assert.sv
bench/memUnitTb.sv

// ==== rtl/addrGen.sv ====
`timescale 1ns/1ps

module addrGen #(
   parameter int addrW = 6
) (
   input  logic               clk,
   input  logic               rstN,
   input  logic               run,
   input  memUnitPkg::agCfg_t cfg,
   output logic [addrW-1:0]   addr,
   output logic               en,
   output logic               done
);
   import memUnitPkg::*;

   agState_t            state;
   logic [PERIOD_W-1:0] delayCnt;
   logic [PERIOD_W-1:0] innerCnt;
   logic [addrW-1:0]    outerCnt;
   logic                idle;
   logic                periodEnd;
   logic                lastPeriod;
   logic [addrW-1:0]    step;

   assign idle = (state == AG_IDLE) || (state == AG_DONE);
   // only the first duty cycles of a period are active
   assign en   = (state == AG_RUN) && (innerCnt < cfg.duty);
   assign done = (state == AG_DONE);

   // a period or count of zero behaves like one
   assign periodEnd  = (cfg.period <= 1) || (innerCnt == cfg.period - 1'b1);
   assign lastPeriod = (cfg.iterations[addrW-1:0] <= 1) ||
                       (outerCnt == cfg.iterations[addrW-1:0] - 1'b1);

   assign step = en ? cfg.incr[addrW-1:0] : '0;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state    <= AG_IDLE;
         delayCnt <= '0;
         innerCnt <= '0;
         outerCnt <= '0;
      end else begin
         case (state)
            AG_IDLE, AG_DONE: begin
               if (run) begin
                  innerCnt <= '0;
                  outerCnt <= '0;
                  delayCnt <= cfg.delay - 1'b1;
                  state    <= (cfg.delay == '0) ? AG_RUN : AG_DELAY;
               end
            end
            AG_DELAY: begin
               if (delayCnt == '0) begin
                  state <= AG_RUN;
               end else begin
                  delayCnt <= delayCnt - 1'b1;
               end
            end
            AG_RUN: begin
               if (periodEnd) begin
                  innerCnt <= '0;
                  if (lastPeriod) begin
                     state <= AG_DONE;
                  end else begin
                     outerCnt <= outerCnt + 1'b1;
                  end
               end else begin
                  innerCnt <= innerCnt + 1'b1;
               end
            end
            default: state <= AG_IDLE;
         endcase
      end
   end

   // incr on active cycles, shift on the period wrap
   always_ff @(posedge clk) begin
      if (run && idle) begin
         addr <= cfg.start[addrW-1:0];
      end else if (state == AG_RUN) begin
         addr <= addr + step + (periodEnd ? cfg.shift[addrW-1:0] : '0);
      end
   end

endmodule

// ==== rtl/apbCfgRegs.sv ====
`timescale 1ns/1ps

module apbCfgRegs #(
   parameter int dataW = 16,
   parameter int addrW = 6
) (
   input  logic               clk,
   input  logic               rstN,
   input  apbPkg::apbReq_t    apbReq,
   output apbPkg::apbRsp_t    apbRsp,
   output memUnitPkg::agCfg_t cfgA,
   output memUnitPkg::agCfg_t cfgB,
   output logic               run,
   input  logic               doneA,
   input  logic               doneB,
   output logic               hostEn,
   output logic               hostWe,
   output logic [addrW-1:0]   hostAddr,
   output logic [dataW-1:0]   hostWdata,
   input  logic [dataW-1:0]   hostRdata
);
   import apbPkg::*;
   import memUnitPkg::*;

   regOff_t     off;
   logic        memWin;
   logic        setup;
   logic        access;
   logic        wrAccess;
   logic        busyQ;
   logic        busy;
   logic        cfgHit;
   logic        slvErr;
   logic [31:0] regRdata;

   // field layout of the three words per port
   function automatic agCfg_t setWord(agCfg_t c, logic [1:0] idx, logic [31:0] w);
      agCfg_t r;
      r = c;
      case (idx)
         2'd0: {r.shift, r.incr, r.start} = w[3*ADDR_MAX_W-1:0];
         2'd1: {r.duty, r.period, r.iterations} = w[2*PERIOD_W+ADDR_MAX_W-1:0];
         default: {r.writeEn, r.reverse, r.delay} = w[PERIOD_W+1:0];
      endcase
      return r;
   endfunction

   function automatic logic [31:0] getWord(agCfg_t c, logic [1:0] idx);
      case (idx)
         2'd0: return 32'({c.shift, c.incr, c.start});
         2'd1: return 32'({c.duty, c.period, c.iterations});
         default: return 32'({c.writeEn, c.reverse, c.delay});
      endcase
   endfunction

   assign memWin   = apbReq.paddr[11];
   assign off      = regOff_t'(apbReq.paddr[10:2]);
   assign setup    = apbReq.psel & ~apbReq.penable;
   assign access   = apbReq.psel & apbReq.penable;
   assign wrAccess = access & apbReq.pwrite & ~memWin;
   assign cfgHit   = ~memWin && (off inside {REG_A0, REG_A1, REG_A2, REG_B0, REG_B1, REG_B2});

   // drops on the first cycle both generators report done
   assign busy = busyQ & ~(doneA & doneB);

   assign slvErr = access & ((busy & (memWin | cfgHit)) |
                             (~memWin & apbReq.pwrite & (off == REG_STATUS)));

   // reads go out in setup so data is back for the access cycle
   assign hostEn    = memWin & ~busy & ((setup & ~apbReq.pwrite) | (access & apbReq.pwrite));
   assign hostWe    = apbReq.pwrite;
   assign hostAddr  = apbReq.paddr[addrW+1:2];
   assign hostWdata = apbReq.pwdata[dataW-1:0];

   always_comb begin
      case (off)
         REG_STATUS: regRdata = {29'b0, doneB, doneA, busy};
         REG_A0:     regRdata = getWord(cfgA, 2'd0);
         REG_A1:     regRdata = getWord(cfgA, 2'd1);
         REG_A2:     regRdata = getWord(cfgA, 2'd2);
         REG_B0:     regRdata = getWord(cfgB, 2'd0);
         REG_B1:     regRdata = getWord(cfgB, 2'd1);
         REG_B2:     regRdata = getWord(cfgB, 2'd2);
         default:    regRdata = '0;
      endcase
   end

   assign apbRsp = '{
      prdata:  memWin ? 32'(hostRdata) : regRdata,
      pready:  1'b1,
      pslverr: slvErr
   };

   always_ff @(posedge clk) begin
      if (!rstN) begin
         run   <= 1'b0;
         busyQ <= 1'b0;
         cfgA  <= '0;
         cfgB  <= '0;
      end else begin
         run <= wrAccess & (off == REG_CTRL) & apbReq.pwdata[0] & ~busy;
         if (run) begin
            busyQ <= 1'b1;
         end else if (doneA && doneB) begin
            busyQ <= 1'b0;
         end
         if (wrAccess && !busy) begin
            case (off)
               REG_A0:  cfgA <= setWord(cfgA, 2'd0, apbReq.pwdata);
               REG_A1:  cfgA <= setWord(cfgA, 2'd1, apbReq.pwdata);
               REG_A2:  cfgA <= setWord(cfgA, 2'd2, apbReq.pwdata);
               REG_B0:  cfgB <= setWord(cfgB, 2'd0, apbReq.pwdata);
               REG_B1:  cfgB <= setWord(cfgB, 2'd1, apbReq.pwdata);
               REG_B2:  cfgB <= setWord(cfgB, 2'd2, apbReq.pwdata);
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== rtl/apbPkg.sv ====
package apbPkg;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [11:0] paddr;
      logic [31:0] pwdata;
   } apbReq_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apbRsp_t;

   // word offsets, paddr[10:2] while paddr[11] is clear
   typedef enum logic [8:0] {
      REG_CTRL   = 9'd0,
      REG_STATUS = 9'd1,
      REG_A0     = 9'd2,
      REG_A1     = 9'd3,
      REG_A2     = 9'd4,
      REG_B0     = 9'd5,
      REG_B1     = 9'd6,
      REG_B2     = 9'd7
   } regOff_t;

endpackage

// ==== rtl/dualPortRam.sv ====
`timescale 1ns/1ps

module dualPortRam #(
   parameter int dataW = 16,
   parameter int addrW = 6
) (
   input  logic             clk,
   input  logic             enA,
   input  logic             weA,
   input  logic [addrW-1:0] addrA,
   input  logic [dataW-1:0] wdataA,
   output logic [dataW-1:0] rdataA,
   input  logic             enB,
   input  logic [addrW-1:0] addrB,
   output logic [dataW-1:0] rdataB
);

   logic [dataW-1:0] mem [2**addrW];

   always_ff @(posedge clk) begin
      if (enA) begin
         if (weA) begin
            mem[addrA] <= wdataA;
         end else begin
            rdataA <= mem[addrA];
         end
      end
   end

   // read only port
   always_ff @(posedge clk) begin
      if (enB) begin
         rdataB <= mem[addrB];
      end
   end

endmodule

// ==== rtl/memUnitPkg.sv ====
package memUnitPkg;

   // counter width for period, duty and delay
   localparam int PERIOD_W = 6;

   // struct fields are sized for the largest supported address
   localparam int ADDR_MAX_W = 10;

   typedef struct packed {
      logic [ADDR_MAX_W-1:0] start;
      logic [ADDR_MAX_W-1:0] incr;
      logic [ADDR_MAX_W-1:0] shift;
      logic [ADDR_MAX_W-1:0] iterations;
      logic [PERIOD_W-1:0]   period;
      logic [PERIOD_W-1:0]   duty;
      logic [PERIOD_W-1:0]   delay;
      logic                  reverse;
      logic                  writeEn;
   } agCfg_t;

   typedef enum logic [1:0] {
      AG_IDLE,
      AG_DELAY,
      AG_RUN,
      AG_DONE
   } agState_t;

endpackage

// ==== rtl/memUnitTop.sv ====
`timescale 1ns/1ps

module memUnitTop #(
   parameter int dataW = 16,
   parameter int addrW = 6
) (
   input  logic             clk,
   input  logic             rstN,
   input  apbPkg::apbReq_t  apbReq,
   output apbPkg::apbRsp_t  apbRsp,
   input  logic [dataW-1:0] dataIn,
   output logic [dataW-1:0] dataA,
   output logic             validA,
   output logic [dataW-1:0] dataB,
   output logic             validB
);
   import memUnitPkg::*;

   agCfg_t           cfgA;
   agCfg_t           cfgB;
   logic             run;
   logic             doneA;
   logic             doneB;
   logic             enA;
   logic             enB;
   logic [addrW-1:0] addrA;
   logic [addrW-1:0] addrB;
   logic             hostEn;
   logic             hostWe;
   logic [addrW-1:0] hostAddr;
   logic [dataW-1:0] hostWdata;
   logic [dataW-1:0] hostRdata;

   apbCfgRegs #(
      .dataW(dataW),
      .addrW(addrW)
   ) regs (
      .clk      (clk),
      .rstN     (rstN),
      .apbReq   (apbReq),
      .apbRsp   (apbRsp),
      .cfgA     (cfgA),
      .cfgB     (cfgB),
      .run      (run),
      .doneA    (doneA),
      .doneB    (doneB),
      .hostEn   (hostEn),
      .hostWe   (hostWe),
      .hostAddr (hostAddr),
      .hostWdata(hostWdata),
      .hostRdata(hostRdata)
   );

   addrGen #(.addrW(addrW)) agA (
      .clk (clk),
      .rstN(rstN),
      .run (run),
      .cfg (cfgA),
      .addr(addrA),
      .en  (enA),
      .done(doneA)
   );

   addrGen #(.addrW(addrW)) agB (
      .clk (clk),
      .rstN(rstN),
      .run (run),
      .cfg (cfgB),
      .addr(addrB),
      .en  (enB),
      .done(doneB)
   );

   portCombiner #(
      .dataW(dataW),
      .addrW(addrW)
   ) comb (
      .clk      (clk),
      .rstN     (rstN),
      .cfgA     (cfgA),
      .cfgB     (cfgB),
      .agAddrA  (addrA),
      .agEnA    (enA),
      .agAddrB  (addrB),
      .agEnB    (enB),
      .hostEn   (hostEn),
      .hostWe   (hostWe),
      .hostAddr (hostAddr),
      .hostWdata(hostWdata),
      .hostRdata(hostRdata),
      .dataIn   (dataIn),
      .dataA    (dataA),
      .validA   (validA),
      .dataB    (dataB),
      .validB   (validB)
   );

endmodule

// ==== rtl/portCombiner.sv ====
`timescale 1ns/1ps

module portCombiner #(
   parameter int dataW = 16,
   parameter int addrW = 6
) (
   input  logic               clk,
   input  logic               rstN,
   input  memUnitPkg::agCfg_t cfgA,
   input  memUnitPkg::agCfg_t cfgB,
   input  logic [addrW-1:0]   agAddrA,
   input  logic               agEnA,
   input  logic [addrW-1:0]   agAddrB,
   input  logic               agEnB,
   input  logic               hostEn,
   input  logic               hostWe,
   input  logic [addrW-1:0]   hostAddr,
   input  logic [dataW-1:0]   hostWdata,
   output logic [dataW-1:0]   hostRdata,
   input  logic [dataW-1:0]   dataIn,
   output logic [dataW-1:0]   dataA,
   output logic               validA,
   output logic [dataW-1:0]   dataB,
   output logic               validB
);

   logic [addrW-1:0] genAddrA;
   logic [addrW-1:0] genAddrB;
   logic             ramEnA;
   logic             ramWeA;
   logic [addrW-1:0] ramAddrA;
   logic [dataW-1:0] ramWdataA;
   logic [dataW-1:0] ramRdataA;
   logic [dataW-1:0] ramRdataB;
   logic [1:0]       vldPipeA;
   logic [1:0]       vldPipeB;

   // fft style reordering
   function automatic logic [addrW-1:0] bitRev(input logic [addrW-1:0] a);
      logic [addrW-1:0] r;
      for (int i = 0; i < addrW; i++) begin
         r[i] = a[addrW-1-i];
      end
      return r;
   endfunction

   assign genAddrA = cfgA.reverse ? bitRev(agAddrA) : agAddrA;
   assign genAddrB = cfgB.reverse ? bitRev(agAddrB) : agAddrB;

   // host owns port A whenever it asks
   assign ramEnA    = hostEn | agEnA;
   assign ramWeA    = hostEn ? hostWe : cfgA.writeEn;
   assign ramAddrA  = hostEn ? hostAddr : genAddrA;
   assign ramWdataA = hostEn ? hostWdata : dataIn;
   assign hostRdata = ramRdataA;

   dualPortRam #(
      .dataW(dataW),
      .addrW(addrW)
   ) ram (
      .clk   (clk),
      .enA   (ramEnA),
      .weA   (ramWeA),
      .addrA (ramAddrA),
      .wdataA(ramWdataA),
      .rdataA(ramRdataA),
      .enB   (agEnB),
      .addrB (genAddrB),
      .rdataB(ramRdataB)
   );

   // ram latency plus output register
   always_ff @(posedge clk) begin
      if (!rstN) begin
         vldPipeA <= '0;
         vldPipeB <= '0;
      end else begin
         vldPipeA <= {vldPipeA[0], agEnA & ~cfgA.writeEn};
         vldPipeB <= {vldPipeB[0], agEnB};
      end
   end

   always_ff @(posedge clk) begin
      dataA <= ramRdataA;
      dataB <= ramRdataB;
   end

   assign validA = vldPipeA[1];
   assign validB = vldPipeB[1];

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the memory unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module memUnitTb -f compile.f -o memUnitSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/memUnitSim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "All tests passed!" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL, see sim.log"
exit 1
